/* common/lineBufConsts.svh */
`ifndef LINE_BUF_CONSTS_SVH
`define LINE_BUF_CONSTS_SVH

// pixel width, one packed RGB888 pixel
`define LB_DATA_W 24

// column address width, lines up to 2048 pixels
`define LB_ADDR_W 11

// line memories in the ring
`define LB_LINES 8

`define LB_WIN 4 // window edge for bicubic taps

// fill count width, must hold LB_LINES
`define LB_FILL_W 4

`define LB_RD_LAT 4 // request to window in cycles

`endif

/* common/lineBufPkg.sv */
`include "lineBufConsts.svh"

package lineBufPkg;

	typedef logic [`LB_DATA_W-1:0] pixel_t;
	typedef logic [`LB_ADDR_W-1:0] colAddr_t;
	typedef logic [`LB_LINES-1:0] lineSel_t; // one-hot
	typedef logic [`LB_FILL_W-1:0] fillCount_t;
	typedef logic [2:0] advance_t; // lines to retire, 0 to 4

	typedef struct packed {
		colAddr_t col; // centre column
		advance_t advance;
	} rdReq_t;

	// tap0 is col-1, tap3 is col+2
	typedef struct packed {
		colAddr_t tap3;
		colAddr_t tap2;
		colAddr_t tap1;
		colAddr_t tap0;
	} tapAddr_t;

	typedef pixel_t [`LB_WIN-1:0] winRow_t;
	typedef winRow_t [`LB_WIN-1:0] window_t; // row 0 is the oldest line

	typedef enum logic [1:0] {sEmpty, sFilling, sWindow, sFull} ctrlState_t;

	// rotate a line selector toward newer lines
	function automatic lineSel_t rotLine(lineSel_t sel, int unsigned n);
		logic [2*`LB_LINES-1:0] twice;
		twice = {sel, sel} << n;
		return twice[2*`LB_LINES-1:`LB_LINES];
	endfunction

endpackage

/* verilog/columnCounter.sv */
`timescale 1ns/1ps

module columnCounter
	import lineBufPkg::*;
(
	input logic clk,
	input logic rst,
	input logic wrAccept,
	input colAddr_t xRes,
	output colAddr_t wrCol,
	output logic lineDone
);

	logic lastCol;

	assign lastCol = (wrCol == xRes - colAddr_t'(1));

	// beat in flight is the last pixel of the line
	assign lineDone = wrAccept && lastCol;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wrCol <= '0;
		end else if (wrAccept) begin
			if (lastCol) begin
				wrCol <= '0; // wrap to next line
			end else begin
				wrCol <= wrCol + colAddr_t'(1);
			end
		end
	end

	// xRes holds from reset, so the column never runs past the line
	wrColInRange: assert property (@(posedge clk) disable iff (rst)
		wrCol < xRes)
		else $error("write column %0d beyond line width %0d", wrCol, xRes);

endmodule

/* verilog/bufferCtrl.sv */
`timescale 1ns/1ps
`include "lineBufConsts.svh"

module bufferCtrl
	import lineBufPkg::*;
(
	input logic clk,
	input logic rst,
	input logic wrValid,
	input logic rdValid,
	input logic lineDone,
	input advance_t rdAdvance,
	output logic wrReady,
	output logic rdReady,
	output logic wrAccept,
	output logic rdAccept,
	output lineSel_t wrLine,
	output lineSel_t rdBase,
	output fillCount_t fillCount
);

	ctrlState_t state;
	ctrlState_t nextState;
	fillCount_t nextFill;
	fillCount_t retire;

	assign wrAccept = wrValid && wrReady;
	assign rdAccept = rdValid && rdReady;

	// lines freed by the accepted request
	assign retire = rdAccept ? fillCount_t'(rdAdvance) : '0;

	assign nextFill = fillCount + fillCount_t'(lineDone) - retire;

	always_comb begin
		if (nextFill == '0) begin
			nextState = sEmpty;
		end else if (nextFill < fillCount_t'(`LB_WIN)) begin
			nextState = sFilling;
		end else if (nextFill < fillCount_t'(`LB_LINES)) begin
			nextState = sWindow;
		end else begin
			nextState = sFull;
		end
	end

	// readies follow the fill level held in the state
	always_comb begin
		case (state)
			sEmpty, sFilling: begin
				wrReady = 1'b1;
				rdReady = 1'b0;
			end
			sWindow: begin
				wrReady = 1'b1;
				rdReady = 1'b1;
			end
			sFull: begin
				wrReady = 1'b0; // every line holds unread data
				rdReady = 1'b1;
			end
			default: begin
				wrReady = 1'b0;
				rdReady = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= sEmpty;
			fillCount <= '0;
			wrLine <= lineSel_t'(1);
			rdBase <= lineSel_t'(1);
		end else begin
			state <= nextState;
			fillCount <= nextFill;
			if (lineDone) begin
				wrLine <= rotLine(wrLine, 1);
			end
			// base moves past the retired lines after this read
			if (rdAccept) begin
				rdBase <= rotLine(rdBase, rdAdvance);
			end
		end
	end

	fillBounded: assert property (@(posedge clk) disable iff (rst)
		fillCount <= fillCount_t'(`LB_LINES))
		else $error("fill count %0d above ring size", fillCount);

	selOneHot: assert property (@(posedge clk) disable iff (rst)
		$onehot(wrLine) && $onehot(rdBase))
		else $error("line selector lost one-hot form");

endmodule

/* lineStore/lineRam.sv */
`timescale 1ns/1ps
`include "lineBufConsts.svh"

module lineRam
	import lineBufPkg::*;
(
	input logic clk,
	input logic we,
	input colAddr_t wrAddr,
	input pixel_t wrData,
	input tapAddr_t rdAddr,
	output winRow_t q
);

	// one full image line
	pixel_t mem [0:(1 << `LB_ADDR_W)-1];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wrAddr] <= wrData;
		end
	end

	// four horizontal taps, registered
	always_ff @(posedge clk) begin
		q[0] <= mem[rdAddr.tap0];
		q[1] <= mem[rdAddr.tap1];
		q[2] <= mem[rdAddr.tap2];
		q[3] <= mem[rdAddr.tap3];
	end

endmodule

/* lineStore/windowFetch.sv */
`timescale 1ns/1ps
`include "lineBufConsts.svh"

module windowFetch
	import lineBufPkg::*;
(
	input logic clk,
	input logic rst,
	input logic wrAccept,
	input logic rdAccept,
	input colAddr_t wrCol,
	input colAddr_t rdCol,
	input colAddr_t xRes,
	input pixel_t wrData,
	input lineSel_t wrLine,
	input lineSel_t rdBase,
	output logic winValid,
	output window_t window
);

	lineSel_t weVec;
	colAddr_t wrAddrQ;
	pixel_t wrDataQ;

	colAddr_t lastCol;
	logic [`LB_ADDR_W:0] colWide;
	tapAddr_t tapNext;
	tapAddr_t tapQ;

	lineSel_t rowSelQ [`LB_WIN];
	lineSel_t rowSelQ2 [`LB_WIN];
	winRow_t ramQ [`LB_LINES];
	window_t rowMux;
	window_t rowData;

	logic [`LB_RD_LAT-1:0] vldPipe;

	// limit a widened column to the last pixel of the line
	function automatic colAddr_t clampCol(logic [`LB_ADDR_W:0] c, colAddr_t last);
		return (c > {1'b0, last}) ? last : c[`LB_ADDR_W-1:0];
	endfunction

	// write stage, one cycle behind acceptance
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			weVec <= '0;
		end else begin
			weVec <= wrAccept ? wrLine : '0;
		end
	end

	always_ff @(posedge clk) begin
		wrAddrQ <= wrCol;
		wrDataQ <= wrData;
	end

	assign lastCol = xRes - colAddr_t'(1);
	assign colWide = {1'b0, rdCol};

	always_comb begin
		tapNext.tap0 = (rdCol == '0) ? '0 : clampCol(colWide - 1'b1, lastCol);
		tapNext.tap1 = clampCol(colWide, lastCol);
		tapNext.tap2 = clampCol(colWide + 1'b1, lastCol);
		tapNext.tap3 = clampCol(colWide + 2'd2, lastCol);
	end

	// stage 1: taps and row selectors, base taken before its own advance
	always_ff @(posedge clk) begin
		tapQ <= tapNext;
		for (int k = 0; k < `LB_WIN; k++) begin
			rowSelQ[k] <= rotLine(rdBase, k);
		end
	end

	// stage 2: memory read
	for (genvar m = 0; m < `LB_LINES; m++) begin : gLine
		lineRam uRam (
			.clk(clk),
			.we(weVec[m]),
			.wrAddr(wrAddrQ),
			.wrData(wrDataQ),
			.rdAddr(tapQ),
			.q(ramQ[m])
		);
	end

	always_ff @(posedge clk) begin
		rowSelQ2 <= rowSelQ;
	end

	// one-hot mux, each row from one of eight memories
	always_comb begin
		for (int k = 0; k < `LB_WIN; k++) begin
			rowMux[k] = '0;
			for (int m = 0; m < `LB_LINES; m++) begin
				if (rowSelQ2[k][m]) begin
					rowMux[k] = rowMux[k] | ramQ[m];
				end
			end
		end
	end

	// stage 3 row select, stage 4 output
	always_ff @(posedge clk) begin
		rowData <= rowMux;
		window <= rowData;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vldPipe <= '0;
		end else begin
			vldPipe <= {vldPipe[`LB_RD_LAT-2:0], rdAccept};
		end
	end

	assign winValid = vldPipe[`LB_RD_LAT-1];

	// write line comes from the controller ring
	singleWrite: assert property (@(posedge clk) disable iff (rst)
		$onehot0(weVec))
		else $error("more than one line memory written");

endmodule

/* verilog/lineBufferTop.sv */
`timescale 1ns/1ps

module lineBufferTop
	import lineBufPkg::*;
(
	input logic clk,
	input logic rst,
	input colAddr_t xRes,
	input logic wrValid,
	input pixel_t wrData,
	output logic wrReady,
	input logic rdValid,
	input rdReq_t rdReq,
	output logic rdReady,
	output logic winValid,
	output window_t window,
	output fillCount_t fillCount
);

	logic wrAccept;
	logic rdAccept;
	logic lineDone;
	colAddr_t wrCol;
	lineSel_t wrLine;
	lineSel_t rdBase;

	bufferCtrl uCtrl (
		.clk(clk),
		.rst(rst),
		.wrValid(wrValid),
		.rdValid(rdValid),
		.lineDone(lineDone),
		.rdAdvance(rdReq.advance),
		.wrReady(wrReady),
		.rdReady(rdReady),
		.wrAccept(wrAccept),
		.rdAccept(rdAccept),
		.wrLine(wrLine),
		.rdBase(rdBase),
		.fillCount(fillCount)
	);

	columnCounter uCol (
		.clk(clk),
		.rst(rst),
		.wrAccept(wrAccept),
		.xRes(xRes),
		.wrCol(wrCol),
		.lineDone(lineDone)
	);

	windowFetch uFetch (
		.clk(clk),
		.rst(rst),
		.wrAccept(wrAccept),
		.rdAccept(rdAccept),
		.wrCol(wrCol),
		.rdCol(rdReq.col),
		.xRes(xRes),
		.wrData(wrData),
		.wrLine(wrLine),
		.rdBase(rdBase),
		.winValid(winValid),
		.window(window)
	);

endmodule

/* tb/lineBufferModel.svh */
`ifndef LINE_BUFFER_MODEL_SVH
`define LINE_BUFFER_MODEL_SVH

// reference ring, line index then column
pixel_t ringMem [`LB_LINES][1 << `LB_ADDR_W];
int mWrLine; // line taking new pixels
int mRdBase; // oldest stored line
int mCol;
int mFill;

function automatic void modelReset();
	mWrLine = 0;
	mRdBase = 0;
	mCol = 0;
	mFill = 0;
endfunction

// edge replication at both ends of the line
function automatic int clampTap(int c, int width);
	if (c < 0) return 0;
	if (c > width - 1) return width - 1;
	return c;
endfunction

function automatic window_t expectWindow(int col, int width);
	window_t w;
	int line;
	for (int r = 0; r < `LB_WIN; r++) begin
		line = (mRdBase + r) % `LB_LINES; // row 0 oldest
		for (int k = 0; k < `LB_WIN; k++) begin
			w[r][k] = ringMem[line][clampTap(col - 1 + k, width)];
		end
	end
	return w;
endfunction

// one clock edge of the ring
function automatic void modelStep(logic wrAcc, pixel_t data, logic rdAcc, int adv, int width);
	int done;
	done = 0;
	if (wrAcc) begin
		ringMem[mWrLine][mCol] = data;
		if (mCol == width - 1) begin
			mCol = 0;
			done = 1;
			mWrLine = (mWrLine + 1) % `LB_LINES;
		end else begin
			mCol++;
		end
	end
	if (rdAcc) begin
		mRdBase = (mRdBase + adv) % `LB_LINES;
		mFill -= adv;
	end
	mFill += done;
endfunction

`endif

/* tb/lineBufferTb.sv */
`timescale 1ns/1ps
`include "lineBufConsts.svh"

module lineBufferTb
	import lineBufPkg::*;
();

	logic clk;
	logic rst;
	colAddr_t xRes;
	logic wrValid;
	pixel_t wrData;
	logic wrReady;
	logic rdValid;
	rdReq_t rdReq;
	logic rdReady;
	logic winValid;
	window_t window;
	fillCount_t fillCount;

	int errors = 0;
	int testErrBase = 0;
	int testCount = 0;
	int cycle = 0;
	int windowsSeen = 0;
	int edgeIdx = 4; // edge columns still to send
	window_t expQ[$];
	int accQ[$]; // acceptance cycle per request

	`include "lineBufferModel.svh"

	lineBufferTop dut (.*);

	task automatic valueError(string name, logic [63:0] got, logic [63:0] exp);
		$display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		errors++;
	endtask

	task automatic failNote(string what);
		$display("%s at %0t", what, $time);
		errors++;
	endtask

	task automatic endTest(string name);
		@(negedge clk); // scoreboard done with the last edge
		testCount++;
		$display("test %0d %s: %0d errors", testCount, name, errors - testErrBase);
		testErrBase = errors;
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// scoreboard, samples the values of the cycle just ended
	always @(posedge clk) begin : monitor
		window_t expWin;
		int accCyc;
		if (!rst) begin
			cycle++;
			assert (fillCount == fillCount_t'(mFill))
				else valueError("fillCount", fillCount, mFill);
			assert (rdReady == (mFill >= `LB_WIN)) else valueError("rdReady", rdReady, mFill >= 4);
			assert (wrReady == (mFill != `LB_LINES)) else valueError("wrReady", wrReady, mFill != 8);
			if (winValid) begin
				assert (expQ.size() != 0) else failNote("window delivered with no request open");
				if (expQ.size() != 0) begin
					expWin = expQ.pop_front();
					accCyc = accQ.pop_front();
					windowsSeen++;
					assert (cycle - accCyc == `LB_RD_LAT)
						else valueError("winValid latency", cycle - accCyc, `LB_RD_LAT);
					for (int r = 0; r < `LB_WIN; r++) begin
						for (int k = 0; k < `LB_WIN; k++) begin
							assert (window[r][k] == expWin[r][k])
								else valueError($sformatf("window[%0d][%0d]", r, k),
									window[r][k], expWin[r][k]);
						end
					end
				end
			end
			if (rdValid && rdReady) begin
				expQ.push_back(expectWindow(int'(rdReq.col), int'(xRes)));
				accQ.push_back(cycle);
			end
			modelStep(wrValid && wrReady, wrData, rdValid && rdReady, int'(rdReq.advance),
				int'(xRes));
		end
	end

	function automatic rdReq_t randReq(int advMax);
		rdReq_t r;
		if (edgeIdx < 4) begin
			case (edgeIdx)
				0: r.col = '0;
				1: r.col = colAddr_t'(1);
				2: r.col = xRes - colAddr_t'(2);
				default: r.col = xRes - colAddr_t'(1);
			endcase
			edgeIdx++;
		end else begin
			r.col = colAddr_t'($urandom_range(int'(xRes) - 1));
		end
		r.advance = advance_t'($urandom_range(advMax));
		return r;
	endfunction

	// one cycle of random traffic, a pending beat holds until it transfers
	task automatic stepStim(int wrPct, int rdPct, int advMax);
		logic rdGo;
		@(posedge clk);
		if (!wrValid || wrReady) begin
			wrValid <= ($urandom_range(99) < wrPct);
			wrData <= pixel_t'($urandom);
		end
		if (!rdValid || rdReady) begin
			rdGo = ($urandom_range(99) < rdPct);
			rdValid <= rdGo;
			if (rdGo) rdReq <= randReq(advMax);
		end
	endtask

	task automatic waitFull(int wrPct);
		int n;
		n = 0;
		while (fillCount != fillCount_t'(`LB_LINES) && n < 4000) begin
			stepStim(wrPct, 0, 0);
			n++;
		end
		assert (n < 4000) else failNote("timeout waiting for eight stored lines");
	endtask

	task automatic drainReads(int wrPct);
		int n;
		n = 0;
		@(negedge clk); // request queue settles after the rising edge
		while ((rdValid || expQ.size() != 0) && n < 1000) begin
			stepStim(wrPct, 0, 0);
			@(negedge clk);
			n++;
		end
		assert (n < 1000) else failNote("timeout waiting for reads to drain");
	endtask

	initial begin
		int n;
		int run;
		int lowSeen;
		void'($urandom(28));
		modelReset();
		rst = 1'b1;
		xRes = colAddr_t'(16);
		wrValid = 1'b0;
		wrData = '0;
		rdValid = 1'b0;
		rdReq = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		assert (wrReady == 1'b1) else valueError("wrReady", wrReady, 1);
		assert (rdReady == 1'b0) else valueError("rdReady", rdReady, 0);
		assert (winValid == 1'b0) else valueError("winValid", winValid, 0);
		assert (fillCount == '0) else valueError("fillCount", fillCount, 0);
		endTest("reset state");

		waitFull(60);
		repeat (6) stepStim(100, 0, 0);
		assert (wrReady == 1'b0) else valueError("wrReady", wrReady, 0);
		endTest("fill eight lines");

		edgeIdx = 0; // first four requests hit the line ends
		repeat (60) stepStim(100, 80, 0);
		drainReads(0);
		endTest("clamped windows");

		repeat (600) stepStim(50, 30, 4);
		drainReads(50);
		endTest("advance and wrap");

		waitFull(100);
		for (int i = 0; i < 5; i++) begin
			rdValid <= 1'b1;
			rdReq <= '{col: colAddr_t'($urandom_range(15)), advance: advance_t'(i < 4)};
			n = 0;
			@(posedge clk);
			while (!rdReady && n < 20) begin
				@(posedge clk);
				n++;
			end
			assert (n < 20) else failNote("timeout waiting for rdReady in burst");
		end
		rdValid <= 1'b0;
		n = 0;
		while (!winValid && n < 20) begin
			@(posedge clk);
			n++;
		end
		assert (n < 20) else failNote("timeout waiting for the first burst window");
		run = 0;
		while (winValid && run < 20) begin
			@(posedge clk);
			run++;
		end
		assert (run == 5) else valueError("winValid run length", run, 5);
		lowSeen = 0;
		for (int i = 0; i < 40; i++) begin
			stepStim(0, 100, 4);
			if (rdValid && fillCount < fillCount_t'(`LB_WIN)) lowSeen++;
		end
		assert (lowSeen > 0) else failNote("fill count never fell below four");
		n = 0;
		@(negedge clk);
		while (expQ.size() != 0 && n < 20) begin
			@(negedge clk);
			n++;
		end
		assert (n < 20) else failNote("timeout waiting for outstanding windows");
		endTest("back-to-back and low fill");

		$display("%0d tests, %0d windows checked, %0d errors", testCount, windowsSeen, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* lineBuffer.f */
+incdir+common
+incdir+tb
common/lineBufPkg.sv
verilog/columnCounter.sv
verilog/bufferCtrl.sv
lineStore/lineRam.sv
lineStore/windowFetch.sv
verilog/lineBufferTop.sv
tb/lineBufferTb.sv

/* runSim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f lineBuffer.f \
	--top-module lineBufferTb -o lineBufferSim \
	&& ./obj_dir/lineBufferSim | tee sim.log \
	|| echo "build or run error" | tee -a sim.log

grep -q "^TB PASSED$" sim.log && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }
